//--- sources.f
design/ide_pkg.sv
design/ide_bus_port.sv
design/taskfile_regs.sv
design/ide_cmd_ctrl.sv
design/disk_store.sv
design/ide_disk_top.sv
sim/tb_ide_disk.sv

//--- Makefile
# Verilator build and run of the ATA PIO disk target testbench.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ide_disk \
		-f sources.f -Mdir obj_dir
	./obj_dir/Vtb_ide_disk | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_ide_disk.sv
// Testbench for the ATA PIO disk target, drives host register cycles and checks sector data.
`timescale 1ns/1ps

module tb_ide_disk;

   localparam int WORDS = ide_pkg::DISK_SECTORS * ide_pkg::SECTOR_WORDS;
   localparam int POLL_LIMIT = 200;

   logic        clk;
   logic        arst_n;
   logic [15:0] data_in;
   logic [15:0] data_out;
   logic        dior;
   logic        diow;
   logic [1:0]  cs;
   logic [2:0]  da;

   logic [31:0] lfsr;
   logic [15:0] ref_disk [WORDS];  // expected disk contents.

   ide_disk_top ide_disk_top_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .data_in  (data_in),
      .data_out (data_out),
      .dior     (dior),
      .diow     (diow),
      .cs       (cs),
      .da       (da)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_word(output logic [15:0] w);
      w = '0;
      for (int i = 0; i < 16; i++)
      begin
         lfsr = lfsr_next(lfsr);
         w = {w[14:0], lfsr[0]};
      end
   endtask

   function automatic logic [15:0] fill_word(input int addr);
      return 16'(addr * 40563 + 27195);  // odd factor, every address bit counts.
   endfunction

   // {status, error} once BSY has dropped after a command.
   function automatic logic [15:0] expect_cmd(input logic [7:0] cmd, input int lba,
                                              input int count);
      int n;
      n = (count == 0) ? 256 : count;
      if (cmd != 8'h20 && cmd != 8'h30)
         return 16'h5104;
      if (lba + n > 16)
         return 16'h5110;
      return 16'h5800;
   endfunction

   task automatic check_equal(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %s: got 0x%04h, expected 0x%04h", name, got, exp);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("Timed out waiting for %s.", what);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic reg_write(input logic ctrl, input logic [2:0] addr, input logic [15:0] value);
      @(negedge clk);
      cs = ctrl ? 2'b01 : 2'b10;
      da = addr;
      data_in = value;
      diow = 1'b0;
      repeat (3) @(negedge clk);
      diow = 1'b1;
      @(negedge clk);
      cs = 2'b11;
   endtask

   task automatic reg_read(input logic ctrl, input logic [2:0] addr, output logic [15:0] value);
      @(negedge clk);
      cs = ctrl ? 2'b01 : 2'b10;
      da = addr;
      dior = 1'b0;
      repeat (3) @(negedge clk);
      value = data_out;  // sampled just before release.
      dior = 1'b1;
      @(negedge clk);
      cs = 2'b11;
   endtask

   task automatic wait_ready(output logic [15:0] st);
      int polls;
      polls = 0;
      reg_read(1'b0, ide_pkg::REG_CMD_STATUS, st);
      while (st[7])
      begin
         polls++;
         if (polls > POLL_LIMIT)
            timeout_abort("BSY to clear");
         reg_read(1'b0, ide_pkg::REG_CMD_STATUS, st);
      end
   endtask

   task automatic issue_cmd(input logic [7:0] cmd, input int lba, input int count);
      logic [15:0] st;
      logic [15:0] err;
      logic [15:0] exp;
      exp = expect_cmd(cmd, lba, count);
      reg_write(1'b0, ide_pkg::REG_COUNT, {8'h00, 8'(count)});
      reg_write(1'b0, ide_pkg::REG_LBA_LOW, {8'h00, 8'(lba)});
      reg_write(1'b0, ide_pkg::REG_LBA_MID, {8'h00, 8'(lba >> 8)});
      reg_write(1'b0, ide_pkg::REG_LBA_HIGH, {8'h00, 8'(lba >> 16)});
      reg_write(1'b0, ide_pkg::REG_DEV_HEAD, {8'h00, 4'he, 4'(lba >> 24)});  // lba mode.
      reg_write(1'b0, ide_pkg::REG_CMD_STATUS, {8'h00, cmd});
      wait_ready(st);
      reg_read(1'b0, ide_pkg::REG_ERR_FEAT, err);
      check_equal("status", st, {8'h00, exp[15:8]});
      check_equal("error", err, {8'h00, exp[7:0]});
   endtask

   task automatic write_sectors(input int lba, input int count, input bit use_fill);
      logic [15:0] w;
      logic [15:0] st;
      int          addr;
      issue_cmd(ide_pkg::CMD_WRITE_SECTORS, lba, count);
      for (int s = 0; s < count; s++)
      begin
         if (s > 0)
         begin
            wait_ready(st);
            check_equal("status", st, 16'h0058);
         end
         for (int i = 0; i < 256; i++)
         begin
            addr = (lba + s) * 256 + i;
            if (use_fill)
               w = fill_word(addr);
            else
               rand_word(w);
            ref_disk[addr] = w;
            reg_write(1'b0, ide_pkg::REG_DATA, w);
         end
      end
      wait_ready(st);
      check_equal("status", st, 16'h0050);
   endtask

   task automatic read_sectors(input int lba, input int count);
      logic [15:0] v;
      int          addr;
      issue_cmd(ide_pkg::CMD_READ_SECTORS, lba, count);
      for (int s = 0; s < count; s++)
      begin
         if (s > 0)
         begin
            wait_ready(v);
            check_equal("status", v, 16'h0058);
         end
         for (int i = 0; i < 256; i++)
         begin
            addr = (lba + s) * 256 + i;
            reg_read(1'b0, ide_pkg::REG_DATA, v);
            check_equal($sformatf("data_out at word %0d", addr), v, ref_disk[addr]);
         end
      end
      wait_ready(v);
      check_equal("status", v, 16'h0050);
   endtask

   initial
   begin
      logic [15:0] v;
      logic [15:0] tf [5];
      arst_n = 1'b0;
      dior = 1'b1;
      diow = 1'b1;
      cs = 2'b11;
      da = 3'd0;
      data_in = 16'h0000;
      lfsr = 32'hc8a353b6;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;

      reg_read(1'b0, ide_pkg::REG_CMD_STATUS, v);
      check_equal("status", v, 16'h0050);
      reg_read(1'b1, ide_pkg::REG_DEV_CTRL, v);
      check_equal("alt_status", v, 16'h0050);
      reg_read(1'b0, ide_pkg::REG_ERR_FEAT, v);
      check_equal("error", v, 16'h0000);
      for (int r = 0; r < 5; r++)
      begin
         rand_word(v);
         tf[r] = {8'h00, v[7:0]};
         reg_write(1'b0, 3'(r + 2), tf[r]);
      end
      for (int r = 0; r < 5; r++)
      begin
         reg_read(1'b0, 3'(r + 2), v);
         check_equal($sformatf("taskfile reg %0d", r + 2), v, tf[r]);
      end

      write_sectors(0, 16, 1'b1);  // known contents everywhere.
      write_sectors(5, 3, 1'b0);
      reg_read(1'b0, ide_pkg::REG_LBA_LOW, v);
      check_equal("lba_low", v, 16'h0008);
      reg_read(1'b0, ide_pkg::REG_COUNT, v);
      check_equal("count", v, 16'h0000);
      read_sectors(4, 5);  // neighbours of the written range too.

      issue_cmd(ide_pkg::CMD_WRITE_SECTORS, 14, 3);
      issue_cmd(8'h91, 2, 1);
      issue_cmd(ide_pkg::CMD_READ_SECTORS, 0, 0);

      // soft reset in the middle of a read.
      issue_cmd(ide_pkg::CMD_READ_SECTORS, 2, 2);
      for (int i = 0; i < 10; i++)
      begin
         reg_read(1'b0, ide_pkg::REG_DATA, v);
         check_equal($sformatf("data_out at word %0d", 512 + i), v, ref_disk[512 + i]);
      end
      reg_write(1'b1, ide_pkg::REG_DEV_CTRL, 16'h0004);
      reg_write(1'b1, ide_pkg::REG_DEV_CTRL, 16'h0000);
      wait_ready(v);
      check_equal("status", v, 16'h0050);
      reg_read(1'b0, ide_pkg::REG_ERR_FEAT, v);
      check_equal("error", v, 16'h0000);
      for (int r = 2; r < 7; r++)
      begin
         reg_read(1'b0, 3'(r), v);
         check_equal($sformatf("taskfile reg %0d", r), v, 16'h0000);
      end
      read_sectors(0, 16);  // whole disk against the model.

      $display("Everything OK");
      $finish;
   end

endmodule

//--- design/ide_disk_top.sv
// ATA PIO disk target top level, connects host port, task file, command FSM and storage.
`timescale 1ns/1ps

module ide_disk_top (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] data_in,
   output logic [15:0] data_out,
   input  logic        dior,
   input  logic        diow,
   input  logic [1:0]  cs,
   input  logic [2:0]  da
);

   ide_pkg::host_access_t       access;
   ide_pkg::taskfile_t          taskfile;
   ide_pkg::status_t            status;
   logic [7:0]                  error;
   logic                        busy;
   logic                        cmd_start;
   logic                        sector_done;
   logic                        soft_reset;
   logic [ide_pkg::ADDR_W-1:0]  disk_addr;
   logic                        disk_we;
   logic [15:0]                 disk_rdata;

   ide_bus_port ide_bus_port_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .data_in    (data_in),
      .dior       (dior),
      .diow       (diow),
      .cs         (cs),
      .da         (da),
      .access     (access),
      .taskfile   (taskfile),
      .status     (status),
      .error      (error),
      .disk_rdata (disk_rdata),
      .data_out   (data_out)
   );

   taskfile_regs taskfile_regs_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .access      (access),
      .sector_done (sector_done),
      .soft_reset  (soft_reset),
      .busy        (busy),
      .taskfile    (taskfile),
      .cmd_start   (cmd_start)
   );

   ide_cmd_ctrl ide_cmd_ctrl_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .access      (access),
      .cmd_start   (cmd_start),
      .taskfile    (taskfile),
      .status      (status),
      .error       (error),
      .busy        (busy),
      .sector_done (sector_done),
      .soft_reset  (soft_reset),
      .disk_addr   (disk_addr),
      .disk_we     (disk_we)
   );

   disk_store disk_store_i (
      .clk   (clk),
      .addr  (disk_addr),
      .we    (disk_we),
      .wdata (access.wdata),
      .rdata (disk_rdata)
   );

endmodule

//--- design/disk_store.sv
// Sector storage of the ATA target, single-port RAM with registered write-first read.
`timescale 1ns/1ps

module disk_store (
   input  logic                       clk,
   input  logic [ide_pkg::ADDR_W-1:0] addr,
   input  logic                       we,
   input  logic [15:0]                wdata,
   output logic [15:0]                rdata
);

   logic [15:0] mem [ide_pkg::DISK_SECTORS * ide_pkg::SECTOR_WORDS];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
         rdata <= wdata;  // write-first.
      end
      else
      begin
         rdata <= mem[addr];
      end
   end

endmodule

//--- design/ide_cmd_ctrl.sv
// Command FSM of the ATA target: range check, sector sequencing, status and error.
`timescale 1ns/1ps

module ide_cmd_ctrl (
   input  logic                        clk,
   input  logic                        arst_n,
   input  ide_pkg::host_access_t       access,
   input  logic                        cmd_start,
   input  ide_pkg::taskfile_t          taskfile,
   output ide_pkg::status_t            status,
   output logic [7:0]                  error,
   output logic                        busy,
   output logic                        sector_done,
   output logic                        soft_reset,
   output logic [ide_pkg::ADDR_W-1:0]  disk_addr,
   output logic                        disk_we
);

   typedef enum logic [2:0] {IDLE, CHECK, PREP, XFER, NEXT} state_t;

   state_t      state;
   logic [7:0]  ptr;
   logic        op_write;
   logic        srst;
   logic [8:0]  count_eff;
   logic [28:0] range_end;
   logic        cmd_ok;
   logic        is_write;
   logic        data_acc;
   logic        last_word;
   logic [31:0] addr_full;

   assign is_write = (taskfile.command == ide_pkg::CMD_WRITE_SECTORS);
   assign cmd_ok = is_write | (taskfile.command == ide_pkg::CMD_READ_SECTORS);
   assign count_eff = (taskfile.count == 8'd0) ? 9'd256 : {1'b0, taskfile.count};
   assign range_end = {1'b0, taskfile.lba} + {20'd0, count_eff};

   // one data word moved by the host.
   assign data_acc = (state == XFER) & ~access.ctrl_blk & (access.reg_sel == ide_pkg::REG_DATA)
                     & (op_write ? access.wr : access.rd_end);
   assign last_word = (ptr == 8'(ide_pkg::SECTOR_WORDS - 1));
   assign sector_done = data_acc & last_word;
   assign disk_we = data_acc & op_write;
   assign addr_full = taskfile.lba * ide_pkg::SECTOR_WORDS + {24'd0, ptr};
   assign disk_addr = addr_full[ide_pkg::ADDR_W-1:0];
   assign soft_reset = srst;
   assign busy = (state != IDLE);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state <= IDLE;
         ptr <= '0;
         op_write <= 1'b0;
         error <= 8'h00;
         srst <= 1'b0;
      end
      else
      begin
         if (access.wr & access.ctrl_blk & (access.reg_sel == ide_pkg::REG_DEV_CTRL))
            srst <= access.wdata[2];
         if (srst)
         begin
            state <= IDLE;
            ptr <= '0;
            op_write <= 1'b0;
            error <= 8'h00;
         end
         else
         begin
            case (state)
               IDLE:
                  if (cmd_start)
                  begin
                     state <= CHECK;
                     error <= 8'h00;
                  end
               CHECK:
               begin
                  op_write <= is_write;
                  ptr <= '0;
                  if (!cmd_ok)
                     error <= ide_pkg::ERR_ABRT;
                  else if (range_end > ide_pkg::DISK_SECTORS)
                     error <= ide_pkg::ERR_IDNF;
                  // writes skip the prefetch cycle.
                  state <= (cmd_ok && is_write && range_end <= ide_pkg::DISK_SECTORS) ? XFER : PREP;
               end
               PREP:
                  state <= (error != 8'h00) ? IDLE : XFER;  // read data settles here.
               XFER:
                  if (data_acc)
                  begin
                     ptr <= ptr + 8'd1;
                     if (last_word)
                        state <= (taskfile.count == 8'd1) ? IDLE : NEXT;
                  end
               NEXT:
                  state <= PREP;  // lba advanced this cycle.
               default:
                  state <= IDLE;
            endcase
         end
      end
   end

   always_comb
   begin
      status = '0;
      status.bsy = (state == CHECK) | (state == PREP) | (state == NEXT);
      status.drq = (state == XFER);
      status.drdy = ~status.bsy;
      status.dsc = ~status.bsy;
      status.err = (state == IDLE) & (error != 8'h00);
   end

   // each sector opens at word 0.
   xfer_from_zero: assert property (@(posedge clk) disable iff (!arst_n)
                                    $rose(status.drq) |-> ptr == '0)
      else $error("sector transfer started off word 0.");

   we_in_write: assert property (@(posedge clk) disable iff (!arst_n)
                                 disk_we |-> taskfile.command == ide_pkg::CMD_WRITE_SECTORS)
      else $error("disk write outside a write command.");

endmodule

//--- design/taskfile_regs.sv
// Task file registers: host writes, command launch and per-sector LBA/count advance.
`timescale 1ns/1ps

module taskfile_regs (
   input  logic                  clk,
   input  logic                  arst_n,
   input  ide_pkg::host_access_t access,
   input  logic                  sector_done,
   input  logic                  soft_reset,
   input  logic                  busy,
   output ide_pkg::taskfile_t    taskfile,
   output logic                  cmd_start
);

   logic tf_wr;

   // writes only land on the command block while the drive is idle.
   assign tf_wr = access.wr & ~access.ctrl_blk & ~busy;
   assign cmd_start = tf_wr & (access.reg_sel == ide_pkg::REG_CMD_STATUS);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         taskfile <= '0;
      end
      else if (soft_reset)
      begin
         taskfile <= '0;
      end
      else if (sector_done)
      begin
         taskfile.lba <= taskfile.lba + 28'd1;
         taskfile.count <= taskfile.count - 8'd1;  // 0 wraps, count of 256.
      end
      else if (tf_wr)
      begin
         case (access.reg_sel)
            ide_pkg::REG_ERR_FEAT:
               taskfile.features <= access.wdata[7:0];
            ide_pkg::REG_COUNT:
               taskfile.count <= access.wdata[7:0];
            ide_pkg::REG_LBA_LOW:
               taskfile.lba[7:0] <= access.wdata[7:0];
            ide_pkg::REG_LBA_MID:
               taskfile.lba[15:8] <= access.wdata[7:0];
            ide_pkg::REG_LBA_HIGH:
               taskfile.lba[23:16] <= access.wdata[7:0];
            ide_pkg::REG_DEV_HEAD:
            begin
               taskfile.dev_head <= access.wdata[7:0];
               taskfile.lba[27:24] <= access.wdata[3:0];  // lba top nibble.
            end
            ide_pkg::REG_CMD_STATUS:
               taskfile.command <= access.wdata[7:0];
            default:
            begin
            end
         endcase
      end
   end

endmodule

//--- design/ide_bus_port.sv
// Host side of the ATA target: strobe sampling, access decode and read-back mux.
`timescale 1ns/1ps

module ide_bus_port (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [15:0]           data_in,
   input  logic                  dior,
   input  logic                  diow,
   input  logic [1:0]            cs,
   input  logic [2:0]            da,
   output ide_pkg::host_access_t access,
   input  ide_pkg::taskfile_t    taskfile,
   input  ide_pkg::status_t      status,
   input  logic [7:0]            error,
   input  logic [15:0]           disk_rdata,
   output logic [15:0]           data_out
);

   logic        dior_q;
   logic        diow_q;
   logic        dior_qq;
   logic        diow_qq;
   logic [1:0]  cs_q;
   logic [2:0]  da_q;
   logic [15:0] wdata_q;
   logic [2:0]  rd_sel;
   logic        rd_ctrl;
   logic        rd_hit;
   logic        sel_any;
   logic        sel_ctrl;
   logic [15:0] rd_mux;

   assign sel_any = (cs_q != 2'b11);
   assign sel_ctrl = cs_q[0] & ~cs_q[1];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         dior_q <= 1'b1;
         diow_q <= 1'b1;
         dior_qq <= 1'b1;
         diow_qq <= 1'b1;
         cs_q <= 2'b11;
         da_q <= '0;
         rd_sel <= '0;
         rd_ctrl <= 1'b0;
         rd_hit <= 1'b0;
      end
      else
      begin
         dior_q <= dior;
         diow_q <= diow;
         dior_qq <= dior_q;
         diow_qq <= diow_q;
         cs_q <= cs;
         da_q <= da;
         if (!dior_q)
         begin
            rd_sel <= da_q;     // keep target of the read until release.
            rd_ctrl <= sel_ctrl;
            rd_hit <= sel_any;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      wdata_q <= data_in;
   end

   always_comb
   begin
      access.wr = diow_qq & ~diow_q & sel_any;
      access.rd_end = ~dior_qq & dior_q & rd_hit;
      access.ctrl_blk = access.rd_end ? rd_ctrl : sel_ctrl;
      access.reg_sel = access.rd_end ? rd_sel : da_q;
      access.wdata = wdata_q;
   end

   always_comb
   begin
      rd_mux = 16'h0000;
      if (sel_ctrl)
      begin
         if (da_q == ide_pkg::REG_DEV_CTRL)
            rd_mux = {8'h00, status};  // alternate status.
      end
      else if (sel_any)
      begin
         case (da_q)
            ide_pkg::REG_DATA:       rd_mux = disk_rdata;
            ide_pkg::REG_ERR_FEAT:   rd_mux = {8'h00, error};
            ide_pkg::REG_COUNT:      rd_mux = {8'h00, taskfile.count};
            ide_pkg::REG_LBA_LOW:    rd_mux = {8'h00, taskfile.lba[7:0]};
            ide_pkg::REG_LBA_MID:    rd_mux = {8'h00, taskfile.lba[15:8]};
            ide_pkg::REG_LBA_HIGH:   rd_mux = {8'h00, taskfile.lba[23:16]};
            ide_pkg::REG_DEV_HEAD:   rd_mux = {8'h00, taskfile.dev_head[7:4], taskfile.lba[27:24]};
            ide_pkg::REG_CMD_STATUS: rd_mux = {8'h00, status};
            default:                 rd_mux = 16'h0000;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!dior_q)
         data_out <= rd_mux;  // follows the register while dior is low.
   end

   strobe_excl: assert property (@(posedge clk) disable iff (!arst_n) dior_q | diow_q)
      else $error("dior and diow sampled low together.");

endmodule

//--- design/ide_pkg.sv
// Shared constants, register map and bus structs for the ATA PIO disk target.
package ide_pkg;

   localparam int DISK_SECTORS = 16;
   localparam int SECTOR_WORDS = 256;
   localparam int ADDR_W = $clog2(DISK_SECTORS * SECTOR_WORDS);

   localparam logic [7:0] CMD_READ_SECTORS = 8'h20;
   localparam logic [7:0] CMD_WRITE_SECTORS = 8'h30;

   // command block, cs[0] low.
   localparam logic [2:0] REG_DATA = 3'd0;
   localparam logic [2:0] REG_ERR_FEAT = 3'd1;
   localparam logic [2:0] REG_COUNT = 3'd2;
   localparam logic [2:0] REG_LBA_LOW = 3'd3;
   localparam logic [2:0] REG_LBA_MID = 3'd4;
   localparam logic [2:0] REG_LBA_HIGH = 3'd5;
   localparam logic [2:0] REG_DEV_HEAD = 3'd6;
   localparam logic [2:0] REG_CMD_STATUS = 3'd7;
   // control block, cs[1] low.
   localparam logic [2:0] REG_DEV_CTRL = 3'd6;

   localparam logic [7:0] ERR_ABRT = 8'h04;
   localparam logic [7:0] ERR_IDNF = 8'h10;

   typedef struct packed {
      logic [2:0]  reg_sel;
      logic        ctrl_blk;
      logic        wr;       // write strobe seen.
      logic        rd_end;   // read strobe released.
      logic [15:0] wdata;
   } host_access_t;

   typedef struct packed {
      logic [7:0]  features;
      logic [7:0]  count;
      logic [27:0] lba;
      logic [7:0]  dev_head;
      logic [7:0]  command;
   } taskfile_t;

   typedef struct packed {
      logic bsy;
      logic drdy;
      logic df;
      logic dsc;
      logic drq;
      logic corr;
      logic idx;
      logic err;
   } status_t;

endpackage
